// File: dv/fruTb.sv
/*
  testbench of the forwarding register unit
  - clock, reset and cycle watchdog
  - lcg data words and a shadow register file for expected reads
  - stimulus table built at time zero, applied one row per cycle
*/

`timescale 1ns/1ps
`default_nettype none

module fruTb import fruPkg::*; ();

  localparam int RegCount = 32;
  localparam int DivRatio = 3;
  localparam int MaxRows  = 128;
  localparam int RpccGap  = 6;    // cycles between the two rpcc WB latches, multiple of 3
  localparam int ChkAll   = 0;    // both operands and waitForData
  localparam int ChkNone  = 1;    // setup row
  localparam int ChkDelta = 2;    // operand2 - operand1 against tExp1

  logic                sys_clk, arstN;
  logic                stepExu, stepMau, stepWb, workExu, workMau, workWb;
  logic                exuCond, mauCond;
  logic [RegAddrW-1:0] regA, regB, exuDest, mauDest;
  logic [DataW-1:0]    exuResData, mauData;
  instrClass           opClass;
  logic [DataW-1:0]    operand1, operand2;
  logic                waitForData, busy;

  // stimulus table, one entry per cycle
  string               tName    [MaxRows];
  logic [7:0]          tCtrl    [MaxRows];   // steps, works, conds
  logic [RegAddrW-1:0] tRegA    [MaxRows];
  logic [RegAddrW-1:0] tRegB    [MaxRows];
  logic [RegAddrW-1:0] tExuDest [MaxRows];
  logic [RegAddrW-1:0] tMauDest [MaxRows];
  logic [DataW-1:0]    tExuRes  [MaxRows];
  logic [DataW-1:0]    tMauData [MaxRows];
  instrClass           tOp      [MaxRows];
  logic [DataW-1:0]    tExp1    [MaxRows];
  logic [DataW-1:0]    tExp2    [MaxRows];
  logic                tExpWait [MaxRows];
  int                  tKind    [MaxRows];
  int                  rowCount;

  // row under construction
  logic                cStepExu, cStepMau, cStepWb, cWorkExu, cWorkMau, cWorkWb;
  logic                cExuCond, cMauCond;
  logic [RegAddrW-1:0] cRegA, cRegB, cExuDest, cMauDest;
  logic [DataW-1:0]    cExuRes, cMauData;
  instrClass           cOp;

  logic [DataW-1:0]    refFile [32];      // what the file should hold
  logic [31:0]         lcgState;
  int                  valueErrs, otherErrs, checks;
  int                  cycleCount, cycleLimit, busyCycles;

  fwdRegUnit #(.RegCount(RegCount), .DivRatio(DivRatio)) i_dut (
    .sys_clk     (sys_clk),     .arstN      (arstN),
    .stepExu     (stepExu),     .stepMau    (stepMau),    .stepWb     (stepWb),
    .workExu     (workExu),     .workMau    (workMau),    .workWb     (workWb),
    .exuCond     (exuCond),     .mauCond    (mauCond),
    .regA        (regA),        .regB       (regB),
    .exuDest     (exuDest),     .mauDest    (mauDest),
    .exuResData  (exuResData),  .mauData    (mauData),
    .opClass     (opClass),
    .operand1    (operand1),    .operand2   (operand2),
    .waitForData (waitForData), .busy       (busy)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;   // 20 ns period
  end

  // watchdog, limit set once the table is known
  initial begin
    cycleCount = 0;
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge sys_clk);
      cycleCount++;
    end
    $display("timeout after %0d cycles, the run did not complete", cycleLimit);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // table building
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic drawRand(output logic [DataW-1:0] v);
    lcgState = lcgNext(lcgState);
    v        = lcgState;
  endtask

  // file read as the decoder sees it, r31 always zero
  function automatic logic [DataW-1:0] expectedRead(input logic [IdxW-1:0] idx);
    return (idx == ZeroReg) ? '0 : refFile[idx];
  endfunction

  task automatic idleRow();
    {cStepExu, cStepMau, cStepWb, cWorkExu, cWorkMau, cWorkWb} = '0;
    {cExuCond, cMauCond} = '0;
    {cRegA, cRegB, cExuDest, cMauDest} = '0;   // all addresses invalid
    cExuRes  = '0;
    cMauData = '0;
    cOp      = aluOp;
  endtask

  task automatic pushRow(input string name, input int kind, input logic [DataW-1:0] e1,
                         input logic [DataW-1:0] e2, input logic ew);
    if (rowCount >= MaxRows) begin
      $display("stimulus table full, row %s dropped", name);
      otherErrs++;
    end else begin
      tName[rowCount]    = name;
      tCtrl[rowCount]    = {cStepExu, cStepMau, cStepWb, cWorkExu, cWorkMau, cWorkWb,
                            cExuCond, cMauCond};
      tRegA[rowCount]    = cRegA;
      tRegB[rowCount]    = cRegB;
      tExuDest[rowCount] = cExuDest;
      tMauDest[rowCount] = cMauDest;
      tExuRes[rowCount]  = cExuRes;
      tMauData[rowCount] = cMauData;
      tOp[rowCount]      = cOp;
      tExp1[rowCount]    = e1;
      tExp2[rowCount]    = e2;
      tExpWait[rowCount] = ew;
      tKind[rowCount]    = kind;
      rowCount++;
    end
  endtask

  task automatic setExu(input logic [IdxW-1:0] idx, input logic [DataW-1:0] val);
    cExuDest = {1'b1, idx};
    cWorkExu = 1'b1;
    cExuCond = 1'b1;
    cExuRes  = val;
  endtask

  task automatic setMau(input logic [IdxW-1:0] idx, input logic [DataW-1:0] val);
    cMauDest = {1'b1, idx};
    cWorkMau = 1'b1;
    cMauCond = 1'b1;
    cMauData = val;
  endtask

  // MAU values that the WB stage latches one edge later
  task automatic setWbSource(input logic [IdxW-1:0] idx, input logic [DataW-1:0] val);
    cStepWb  = 1'b1;
    cWorkWb  = 1'b1;
    cMauCond = 1'b1;
    cMauDest = {1'b1, idx};
    cMauData = val;
  endtask

  task automatic readPair(input string name, input logic [RegAddrW-1:0] a,
                          input logic [RegAddrW-1:0] b);
    idleRow();
    cRegA = a;
    cRegB = b;
    pushRow(name, ChkAll, expectedRead(a[IdxW-1:0]), expectedRead(b[IdxW-1:0]), 1'b0);
  endtask

  // WB source row, then a row that empties the WB stage behind it
  task automatic writeReg(input logic [IdxW-1:0] idx, input logic [DataW-1:0] val,
                          input logic valid, input logic cond, input logic work);
    idleRow();
    setWbSource(idx, val);
    cMauDest[RegAddrW-1] = valid;
    cMauCond             = cond;
    cWorkWb              = work;
    pushRow("wbSource", ChkNone, '0, '0, 1'b0);
    idleRow();
    cStepWb = 1'b1;                           // flush, no work
    pushRow("wbFlush", ChkNone, '0, '0, 1'b0);
    if (valid && cond && work) refFile[idx] = val;
  endtask

  task automatic buildTable();
    logic [DataW-1:0] v, e, m;
    rowCount = 0;
    for (int r = 0; r < 32; r++) refFile[r] = '0;
    idleRow();
    cExuDest = {1'b1, 5'd20};                 // load waiting in decode, never stepped
    cWorkExu = 1'b1;
    cExuCond = 1'b1;
    cRegA    = {1'b1, 5'd20};
    cOp      = loadOp;
    pushRow("resetHold", ChkNone, '0, '0, 1'b0);   // driven through reset and clear

    // cleared file, every entry once on each port
    for (int r = 0; r < 32; r++) begin
      readPair("clearRead", {1'b1, IdxW'(r)}, {1'b1, IdxW'(31 - r)});
    end

    // writeback, good writes then the three ways of not writing
    for (int r = 0; r < 10; r++) begin
      drawRand(v);
      writeReg(IdxW'(r), v, 1'b1, 1'b1, 1'b1);
    end
    drawRand(v);
    writeReg(ZeroReg, v, 1'b1, 1'b1, 1'b1);   // stored, still reads zero
    for (int r = 0; r < 10; r += 2) begin
      readPair("wbRead", {1'b1, IdxW'(r)}, {1'b1, IdxW'(r + 1)});
    end
    readPair("wbReadR31", {1'b1, ZeroReg}, {1'b0, ZeroReg});
    drawRand(v);
    writeReg(5'd5, v, 1'b1, 1'b0, 1'b1);
    readPair("wbCondFalse", {1'b1, 5'd5}, {1'b1, 5'd5});
    drawRand(v);
    writeReg(5'd5, v, 1'b0, 1'b1, 1'b1);
    readPair("wbDestInvalid", {1'b1, 5'd5}, {1'b1, 5'd5});
    drawRand(v);
    writeReg(5'd5, v, 1'b1, 1'b1, 1'b0);
    readPair("wbNoWork", {1'b1, 5'd5}, {1'b1, 5'd5});

    //////////////////////////////////////////////////////////////////////
    // forwarding priority on r12, WB latched fresh so file still differs
    //////////////////////////////////////////////////////////////////////
    drawRand(v);
    writeReg(5'd12, v, 1'b1, 1'b1, 1'b1);
    for (int k = 0; k < 3; k++) begin
      drawRand(v);
      drawRand(e);
      drawRand(m);
      idleRow();
      setWbSource(5'd12, v);
      cStepExu = (k == 0);                    // alu in EXU, no load flag
      pushRow("fwdSetup", ChkNone, '0, '0, 1'b0);
      idleRow();
      if (k == 0) setExu(5'd12, e);
      if (k < 2) setMau(5'd12, m);
      cRegA = {1'b1, 5'd12};
      cRegB = {1'b1, 5'd12};
      case (k)
        0:       pushRow("fwdExu", ChkAll, e, e, 1'b0);
        1:       pushRow("fwdMau", ChkAll, m, m, 1'b0);
        default: pushRow("fwdWb", ChkAll, v, v, 1'b0);
      endcase
      refFile[12] = v;                        // written at the following edge
    end
    idleRow();
    cStepWb = 1'b1;
    pushRow("fwdFlush", ChkNone, '0, '0, 1'b0);
    readPair("fwdFile", {1'b1, 5'd12}, {1'b1, 5'd12});
    drawRand(v);
    drawRand(e);
    drawRand(m);
    idleRow();
    setWbSource(ZeroReg, v);
    pushRow("fwdR31Setup", ChkNone, '0, '0, 1'b0);
    idleRow();
    setExu(ZeroReg, e);
    setMau(ZeroReg, m);
    cRegA = {1'b1, ZeroReg};
    cRegB = {1'b0, ZeroReg};
    pushRow("fwdR31", ChkAll, '0, '0, 1'b0);

    // load dependency on r20
    drawRand(v);
    writeReg(5'd20, v, 1'b1, 1'b1, 1'b1);
    drawRand(v);
    writeReg(5'd21, v, 1'b1, 1'b1, 1'b1);
    drawRand(e);
    idleRow();
    setExu(5'd20, e);
    cStepExu = 1'b1;
    cOp      = loadOp;
    pushRow("loadSetup", ChkNone, '0, '0, 1'b0);
    cStepExu = 1'b0;                          // load flag held from here
    cRegA    = {1'b1, 5'd20};
    cRegB    = {1'b1, 5'd21};
    pushRow("loadHitA", ChkAll, expectedRead(5'd20), expectedRead(5'd21), 1'b1);
    cRegA = {1'b1, 5'd3};
    cRegB = {1'b1, 5'd20};
    pushRow("loadHitB", ChkAll, expectedRead(5'd3), expectedRead(5'd20), 1'b1);
    cRegA = {1'b1, 5'd21};
    cRegB = {1'b1, 5'd22};
    pushRow("loadMiss", ChkAll, expectedRead(5'd21), expectedRead(5'd22), 1'b0);
    cExuDest = {1'b1, ZeroReg};               // r31 never waits
    cRegA    = {1'b1, ZeroReg};
    pushRow("loadR31", ChkAll, '0, expectedRead(5'd22), 1'b0);
    cExuDest = {1'b1, 5'd20};
    cWorkExu = 1'b0;
    cRegA    = {1'b1, 5'd20};
    pushRow("loadNoWork", ChkAll, expectedRead(5'd20), expectedRead(5'd22), 1'b0);
    drawRand(e);
    setExu(5'd20, e);
    cStepExu = 1'b1;
    cOp      = aluOp;
    pushRow("aluSetup", ChkNone, '0, '0, 1'b0);
    cStepExu = 1'b0;
    pushRow("aluNoWait", ChkAll, e, expectedRead(5'd22), 1'b0);

    // rpcc into r25, then RpccGap cycles later into r26
    idleRow();
    cStepExu = 1'b1;
    cOp      = rpccOp;
    pushRow("rpccExu", ChkNone, '0, '0, 1'b0);
    idleRow();
    cStepMau = 1'b1;
    pushRow("rpccMau", ChkNone, '0, '0, 1'b0);
    drawRand(v);
    idleRow();
    setWbSource(5'd25, v);                    // data replaced by the counter
    pushRow("rpccWb", ChkNone, '0, '0, 1'b0);
    idleRow();
    repeat (RpccGap - 4) pushRow("rpccGap", ChkNone, '0, '0, 1'b0);
    cStepExu = 1'b1;
    cOp      = rpccOp;
    pushRow("rpccExu", ChkNone, '0, '0, 1'b0);
    idleRow();
    cStepMau = 1'b1;
    pushRow("rpccMau", ChkNone, '0, '0, 1'b0);
    idleRow();
    pushRow("rpccGap", ChkNone, '0, '0, 1'b0);
    setWbSource(5'd26, v);
    pushRow("rpccWb", ChkNone, '0, '0, 1'b0);
    idleRow();
    cStepWb = 1'b1;
    pushRow("rpccFlush", ChkNone, '0, '0, 1'b0);
    idleRow();
    cRegA = {1'b1, 5'd25};
    cRegB = {1'b1, 5'd26};
    pushRow("rpccDelta", ChkDelta, DataW'(RpccGap / DivRatio), '0, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // apply and check
  //////////////////////////////////////////////////////////////////////

  task automatic driveRow(input int i);
    {stepExu, stepMau, stepWb, workExu, workMau, workWb, exuCond, mauCond} = tCtrl[i];
    regA       = tRegA[i];
    regB       = tRegB[i];
    exuDest    = tExuDest[i];
    mauDest    = tMauDest[i];
    exuResData = tExuRes[i];
    mauData    = tMauData[i];
    opClass    = tOp[i];
  endtask

  task automatic checkRow(input int i);
    logic [DataW-1:0] delta;
    delta = operand2 - operand1;
    if (tKind[i] == ChkAll) begin
      checks++;
      assert (operand1 === tExp1[i]) else begin
        $display("FAILED %s operand1 expected %h actual %h", tName[i], tExp1[i], operand1);
        valueErrs++;
      end
      assert (operand2 === tExp2[i]) else begin
        $display("FAILED %s operand2 expected %h actual %h", tName[i], tExp2[i], operand2);
        valueErrs++;
      end
      assert (waitForData === tExpWait[i]) else begin
        $display("FAILED %s waitForData expected %b actual %b", tName[i], tExpWait[i],
                 waitForData);
        valueErrs++;
      end
    end else if (tKind[i] == ChkDelta) begin
      checks++;
      assert (delta === tExp1[i]) else begin
        $display("FAILED %s counter delta expected %0d actual %0d", tName[i], tExp1[i], delta);
        valueErrs++;
      end
    end
  endtask

  initial begin
    arstN     = 1'b0;
    lcgState  = 32'h4f85539c;
    valueErrs = 0;
    otherErrs = 0;
    checks    = 0;
    buildTable();
    driveRow(0);
    cycleLimit = rowCount + RegCount + 50;
    repeat (4) @(negedge sys_clk);
    arstN = 1'b1;

    // clear sweep, busy counted in cycles after release
    busyCycles = 0;
    while (busy) begin
      @(negedge sys_clk);
      busyCycles++;
      assert (!waitForData) else begin
        $display("waitForData went high while the file was being cleared");
        otherErrs++;
      end
    end
    checks++;
    assert (busyCycles == RegCount + 1) else begin
      $display("FAILED busyRelease expected %0d actual %0d", RegCount + 1, busyCycles);
      valueErrs++;
    end

    for (int i = 1; i < rowCount; i++) begin
      @(negedge sys_clk);
      driveRow(i);
      @(posedge sys_clk);
      #8;                                     // just ahead of the next falling edge
      checkRow(i);
    end

    $display("checks %0d, value errors %0d, other errors %0d", checks, valueErrs, otherErrs);
    if (valueErrs == 0 && otherErrs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# build the forwarding register unit testbench with Verilator and run it
# the run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module fruTb -f verilog.f -o fruSim \
  && ./obj_dir/fruSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verilog.f
verilog/fruPkg.sv
verilog/clearSequencer.sv
verilog/rpccCounter.sv
verilog/mirrorPipe.sv
verilog/regFile.sv
verilog/operandForward.sv
verilog/fwdRegUnit.sv
dv/fruTb.sv

// File: verilog/clearSequencer.sv
/*
  register file clear sequencer
  - idle in reset, then one zero write per cycle
  - busy until every entry is cleared
*/

`timescale 1ns/1ps
`default_nettype none

module clearSequencer import fruPkg::*; #(
  parameter int RegCount = 32
) (
  input  logic            sys_clk,
  input  logic            arstN,
  output logic            clearing,   // file write port owned by the sweep
  output logic            busy,
  output logic [IdxW-1:0] clearIdx    // entry being zeroed
);

  localparam logic [IdxW-1:0] LastIdx = IdxW'(RegCount - 1);

  clrState state;

  always_ff @(posedge sys_clk or negedge arstN) begin
    if (!arstN) begin
      state    <= clrIdle;
      clearIdx <= '0;
    end else begin
      case (state)
        clrIdle: begin              // first edge after release
          state    <= clrSweep;
          clearIdx <= '0;
        end
        clrSweep: begin
          if (clearIdx == LastIdx) begin
            state <= clrRun;        // last entry written at this edge
          end else begin
            clearIdx <= clearIdx + 1'b1;
          end
        end
        default: state <= clrRun;   // stay until the next reset
      endcase
    end
  end

  assign clearing = (state == clrSweep);
  assign busy     = (state != clrRun);   // idle counts as busy too

endmodule

`default_nettype wire

// File: verilog/fruPkg.sv
/*
  shared definitions of the forwarding register unit
  - data, index and address widths
  - zero register index
  - instruction class, operand source and clear state enums
*/

`default_nettype none

package fruPkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int DataW    = 32;           // operand / result width
  localparam int IdxW     = 5;            // register index width
  localparam int RegAddrW = IdxW + 1;     // msb is the valid flag

  // r31 is hardwired to zero on the read side
  localparam logic [IdxW-1:0] ZeroReg = 5'd31;

  //////////////////////////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////////////////////////

  // class of the instruction stepping into EXU
  typedef enum logic [1:0] {
    aluOp   = 2'd0,   // plain alu result, forwardable from EXU
    loadOp  = 2'd1,   // data only available after MAU
    storeOp = 2'd2,
    rpccOp  = 2'd3    // writes the cycle counter at WB
  } instrClass;

  // operand mux select, freshest source first
  typedef enum logic [1:0] {
    selExu  = 2'd0,
    selMau  = 2'd1,
    selWb   = 2'd2,
    selFile = 2'd3
  } opndSel;

  // register file clear sequencer
  typedef enum logic [1:0] {
    clrIdle  = 2'd0,  // held here in reset
    clrSweep = 2'd1,  // one entry zeroed per cycle
    clrRun   = 2'd2   // normal operation
  } clrState;

endpackage

`default_nettype wire

// File: verilog/fwdRegUnit.sv
/*
  forwarding register unit, top level
  - clear sequencer and rpcc counter
  - mirror of the EXU / MAU / WB stages
  - register file and operand forwarding
*/

`timescale 1ns/1ps
`default_nettype none

module fwdRegUnit import fruPkg::*; #(
  parameter int RegCount = 32,      // register file entries
  parameter int DivRatio = 1        // rpcc divisor, 1..16
) (
  input  logic                sys_clk,
  input  logic                arstN,
  input  logic                stepExu,      // pipeline controller steps
  input  logic                stepMau,
  input  logic                stepWb,
  input  logic                workExu,      // valid work per stage
  input  logic                workMau,
  input  logic                workWb,
  input  logic                exuCond,      // 0 on a false cmov
  input  logic                mauCond,
  input  logic [RegAddrW-1:0] regA,         // operand addresses from decode
  input  logic [RegAddrW-1:0] regB,
  input  logic [RegAddrW-1:0] exuDest,
  input  logic [RegAddrW-1:0] mauDest,
  input  logic [DataW-1:0]    exuResData,
  input  logic [DataW-1:0]    mauData,
  input  instrClass           opClass,
  output logic [DataW-1:0]    operand1,
  output logic [DataW-1:0]    operand2,
  output logic                waitForData,  // stall request to the controller
  output logic                busy          // high while the file is cleared
);

  logic                clearing;
  logic [IdxW-1:0]     clearIdx;
  logic [DataW-1:0]    rpccValue;

  // sampled copies out of the mirror
  logic [RegAddrW-1:0] regAQ, regBQ, exuDestQ, mauDestQ;
  logic [DataW-1:0]    exuData, mauDataQ;
  logic                workExuQ, workMauQ, exuCondQ, mauCondQ;
  logic                exuFromMem;

  // WB stage
  logic [RegAddrW-1:0] wbDest;
  logic [DataW-1:0]    wbData;
  logic                wbCond, wbWork, wbWrite;

  logic [DataW-1:0]    readA, readB;   // file read ports

  //////////////////////////////////////////////////////////////////////
  // housekeeping
  //////////////////////////////////////////////////////////////////////

  clearSequencer #(.RegCount(RegCount)) i_clearSeq (
    .sys_clk  (sys_clk),
    .arstN    (arstN),
    .clearing (clearing),
    .busy     (busy),
    .clearIdx (clearIdx)
  );

  rpccCounter #(.DivRatio(DivRatio)) i_rpcc (
    .sys_clk   (sys_clk),
    .arstN     (arstN),
    .rpccValue (rpccValue)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  mirrorPipe i_mirror (
    .sys_clk    (sys_clk),    .arstN      (arstN),
    .stepExu    (stepExu),    .stepMau    (stepMau),    .stepWb     (stepWb),
    .workExu    (workExu),    .workMau    (workMau),    .workWb     (workWb),
    .exuCond    (exuCond),    .mauCond    (mauCond),
    .regA       (regA),       .regB       (regB),
    .exuDest    (exuDest),    .mauDest    (mauDest),
    .exuResData (exuResData), .mauData    (mauData),
    .opClass    (opClass),    .rpccValue  (rpccValue),
    .regAQ      (regAQ),      .regBQ      (regBQ),
    .exuDestQ   (exuDestQ),   .mauDestQ   (mauDestQ),
    .exuData    (exuData),    .mauDataQ   (mauDataQ),
    .workExuQ   (workExuQ),   .workMauQ   (workMauQ),
    .exuCondQ   (exuCondQ),   .mauCondQ   (mauCondQ),
    .exuFromMem (exuFromMem),
    .wbDest     (wbDest),     .wbData     (wbData),
    .wbCond     (wbCond),     .wbWork     (wbWork),     .wbWrite    (wbWrite)
  );

  regFile #(.RegCount(RegCount)) i_regFile (
    .sys_clk  (sys_clk),
    .clearing (clearing),
    .clearIdx (clearIdx),
    .wbWrite  (wbWrite),
    .wbDest   (wbDest),
    .wbData   (wbData),
    .readIdxA (regAQ[IdxW-1:0]),     // valid flag not needed for a read
    .readIdxB (regBQ[IdxW-1:0]),
    .readA    (readA),
    .readB    (readB)
  );

  operandForward i_fwd (
    .regAQ       (regAQ),     .regBQ      (regBQ),
    .exuDestQ    (exuDestQ),  .mauDestQ   (mauDestQ),
    .workExuQ    (workExuQ),  .workMauQ   (workMauQ),
    .exuCondQ    (exuCondQ),  .mauCondQ   (mauCondQ),
    .exuFromMem  (exuFromMem),
    .exuData     (exuData),   .mauDataQ   (mauDataQ),
    .wbDest      (wbDest),    .wbData     (wbData),
    .wbCond      (wbCond),    .wbWork     (wbWork),
    .readA       (readA),     .readB      (readB),
    .operand1    (operand1),  .operand2   (operand2),
    .waitForData (waitForData)
  );

endmodule

`default_nettype wire

// File: verilog/mirrorPipe.sv
/*
  input sampling and mirror pipe
  - every unit input registered at each edge
  - EXU, MAU and WB mirror stages, gated by the sampled steps
  - WB data with rpcc substitution and the write decision
*/

`timescale 1ns/1ps
`default_nettype none

module mirrorPipe import fruPkg::*; (
  input  logic                sys_clk,
  input  logic                arstN,
  input  logic                stepExu,
  input  logic                stepMau,
  input  logic                stepWb,
  input  logic                workExu,
  input  logic                workMau,
  input  logic                workWb,
  input  logic                exuCond,
  input  logic                mauCond,
  input  logic [RegAddrW-1:0] regA,
  input  logic [RegAddrW-1:0] regB,
  input  logic [RegAddrW-1:0] exuDest,
  input  logic [RegAddrW-1:0] mauDest,
  input  logic [DataW-1:0]    exuResData,
  input  logic [DataW-1:0]    mauData,
  input  instrClass           opClass,
  input  logic [DataW-1:0]    rpccValue,
  output logic [RegAddrW-1:0] regAQ,
  output logic [RegAddrW-1:0] regBQ,
  output logic [RegAddrW-1:0] exuDestQ,
  output logic [RegAddrW-1:0] mauDestQ,
  output logic [DataW-1:0]    exuData,
  output logic [DataW-1:0]    mauDataQ,
  output logic                workExuQ,
  output logic                workMauQ,
  output logic                exuCondQ,
  output logic                mauCondQ,
  output logic                exuFromMem,  // EXU holds a load
  output logic [RegAddrW-1:0] wbDest,
  output logic [DataW-1:0]    wbData,
  output logic                wbCond,
  output logic                wbWork,
  output logic                wbWrite
);

  logic      stepExuQ, stepMauQ, stepWbQ, workWbQ;
  instrClass opClassQ;
  logic      exuRpcc, mauRpcc;   // rpcc flag riding down the mirror

  //////////////////////////////////////////////////////////////////////
  // input sampling
  //////////////////////////////////////////////////////////////////////

  // steps and works settle late in the cycle, so freeze them here
  always_ff @(posedge sys_clk or negedge arstN) begin
    if (!arstN) begin
      stepExuQ <= 1'b0;
      stepMauQ <= 1'b0;
      stepWbQ  <= 1'b0;
      workExuQ <= 1'b0;
      workMauQ <= 1'b0;
      workWbQ  <= 1'b0;
      exuCondQ <= 1'b0;
      mauCondQ <= 1'b0;
      regAQ    <= '0;      // valid flags drop with it
      regBQ    <= '0;
      exuDestQ <= '0;
      mauDestQ <= '0;
      opClassQ <= aluOp;
    end else begin
      stepExuQ <= stepExu;
      stepMauQ <= stepMau;
      stepWbQ  <= stepWb;
      workExuQ <= workExu;
      workMauQ <= workMau;
      workWbQ  <= workWb;
      exuCondQ <= exuCond;
      mauCondQ <= mauCond;
      regAQ    <= regA;
      regBQ    <= regB;
      exuDestQ <= exuDest;
      mauDestQ <= mauDest;
      opClassQ <= opClass;
    end
  end

  // payload only
  always_ff @(posedge sys_clk) begin
    exuData  <= exuResData;
    mauDataQ <= mauData;
  end

  //////////////////////////////////////////////////////////////////////
  // mirror stages
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge arstN) begin
    if (!arstN) begin
      exuFromMem <= 1'b0;
      exuRpcc    <= 1'b0;
      mauRpcc    <= 1'b0;
      wbDest     <= '0;
      wbCond     <= 1'b0;
      wbWork     <= 1'b0;
    end else begin
      if (stepExuQ) begin
        exuFromMem <= (opClassQ == loadOp);  // no EXU forwarding for loads
        exuRpcc    <= (opClassQ == rpccOp);
      end
      if (stepMauQ) mauRpcc <= exuRpcc;
      if (stepWbQ) begin
        wbDest <= mauDestQ;
        wbCond <= mauCondQ;
        wbWork <= workWbQ;
      end
    end
  end

  // rpcc result replaces the MAU data on the way into WB
  always_ff @(posedge sys_clk) begin
    if (stepWbQ) wbData <= mauRpcc ? rpccValue : mauDataQ;
  end

  // the one place that decides a file write
  assign wbWrite = wbWork & wbDest[RegAddrW-1] & wbCond;

endmodule

`default_nettype wire

// File: verilog/operandForward.sv
/*
  operand forwarding
  - address compare against EXU, MAU and WB destinations
  - per operand source select, r31 reads zero
  - load dependency request towards the controller
*/

`timescale 1ns/1ps
`default_nettype none

module operandForward import fruPkg::*; (
  input  logic [RegAddrW-1:0] regAQ,
  input  logic [RegAddrW-1:0] regBQ,
  input  logic [RegAddrW-1:0] exuDestQ,
  input  logic [RegAddrW-1:0] mauDestQ,
  input  logic                workExuQ,
  input  logic                workMauQ,
  input  logic                exuCondQ,
  input  logic                mauCondQ,
  input  logic                exuFromMem,
  input  logic [DataW-1:0]    exuData,
  input  logic [DataW-1:0]    mauDataQ,
  input  logic [RegAddrW-1:0] wbDest,
  input  logic [DataW-1:0]    wbData,
  input  logic                wbCond,
  input  logic                wbWork,
  input  logic [DataW-1:0]    readA,
  input  logic [DataW-1:0]    readB,
  output logic [DataW-1:0]    operand1,
  output logic [DataW-1:0]    operand2,
  output logic                waitForData
);

  opndSel selA, selB;
  logic   loadHitA, loadHitB;

  //////////////////////////////////////////////////////////////////////
  // compare
  //////////////////////////////////////////////////////////////////////

  // address valid and equal to a valid destination
  function automatic logic addrHit(input logic [RegAddrW-1:0] addr,
                                   input logic [RegAddrW-1:0] dest);
    return addr[RegAddrW-1] && (addr == dest);
  endfunction

  // freshest pending producer wins
  function automatic opndSel pickSrc(input logic [RegAddrW-1:0] addr);
    opndSel sel;
    if (addrHit(addr, exuDestQ) && workExuQ && exuCondQ && !exuFromMem) begin
      sel = selExu;
    end else if (addrHit(addr, mauDestQ) && workMauQ && mauCondQ) begin
      sel = selMau;
    end else if (addrHit(addr, wbDest) && wbWork && wbCond) begin
      sel = selWb;
    end else begin
      sel = selFile;                   // nothing in flight
    end
    return sel;
  endfunction

  // load in EXU, data not ready before MAU
  function automatic logic loadHit(input logic [RegAddrW-1:0] addr);
    return addrHit(addr, exuDestQ) && (addr[IdxW-1:0] != ZeroReg) &&
           exuFromMem && workExuQ;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // operand mux
  //////////////////////////////////////////////////////////////////////

  function automatic logic [DataW-1:0] muxOpnd(input logic [RegAddrW-1:0] addr,
                                               input opndSel              sel,
                                               input logic [DataW-1:0]    fileData);
    logic [DataW-1:0] val;
    case (sel)
      selExu:  val = exuData;
      selMau:  val = mauDataQ;
      selWb:   val = wbData;
      default: val = fileData;
    endcase
    if (addr[IdxW-1:0] == ZeroReg) val = '0;   // r31, valid flag or not
    return val;
  endfunction

  always_comb begin
    selA     = pickSrc(regAQ);
    selB     = pickSrc(regBQ);
    loadHitA = loadHit(regAQ);
    loadHitB = loadHit(regBQ);
    operand1 = muxOpnd(regAQ, selA, readA);
    operand2 = muxOpnd(regBQ, selB, readB);
  end

  assign waitForData = loadHitA | loadHitB;     // controller holds EXU

endmodule

`default_nettype wire

// File: verilog/regFile.sv
/*
  register file
  - RegCount words, two combinational read ports
  - one clocked write port, clear sweep over writeback
*/

`timescale 1ns/1ps
`default_nettype none

module regFile import fruPkg::*; #(
  parameter int RegCount = 32
) (
  input  logic                sys_clk,
  input  logic                clearing,   // sweep owns the write port
  input  logic [IdxW-1:0]     clearIdx,
  input  logic                wbWrite,
  input  logic [RegAddrW-1:0] wbDest,
  input  logic [DataW-1:0]    wbData,
  input  logic [IdxW-1:0]     readIdxA,
  input  logic [IdxW-1:0]     readIdxB,
  output logic [DataW-1:0]    readA,
  output logic [DataW-1:0]    readB
);

  logic [DataW-1:0] mem [RegCount];

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // r31 is written like any other entry, the read mux hides it
  always_ff @(posedge sys_clk) begin
    if (clearing) begin
      mem[clearIdx] <= '0;                  // WB writes dropped meanwhile
    end else if (wbWrite) begin
      mem[wbDest[IdxW-1:0]] <= wbData;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read ports
  //////////////////////////////////////////////////////////////////////

  // zero latency, a same cycle WB value comes in through forwarding
  assign readA = mem[readIdxA];
  assign readB = mem[readIdxB];

endmodule

`default_nettype wire

// File: verilog/rpccCounter.sv
/*
  read process cycle counter
  - clock divider, 1..16
  - 32 bit count of divided ticks
*/

`timescale 1ns/1ps
`default_nettype none

module rpccCounter import fruPkg::*; #(
  parameter int DivRatio = 1
) (
  input  logic             sys_clk,
  input  logic             arstN,
  output logic [DataW-1:0] rpccValue
);

  localparam logic [3:0] DivLast = 4'(DivRatio - 1);

  logic [3:0] divCnt;   // cycles within one divided tick

  always_ff @(posedge sys_clk or negedge arstN) begin
    if (!arstN) begin
      divCnt    <= '0;
      rpccValue <= '0;
    end else if (divCnt == DivLast) begin
      divCnt    <= '0;
      rpccValue <= rpccValue + 1'b1;   // wraps at the top
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

endmodule

`default_nettype wire
